// ==== hdl/ctrl_macros.svh ====
/* Sizing constants for the controller port subsystem.
   Include this before anything that sizes pad or mouse logic. */

`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// ======================================================================
// Pad side
// ======================================================================

// Host pads reachable through the multitap
`define CTRL_NUM_PADS 5

// Host pad word, directions plus six buttons
`define CTRL_PAD_BITS 12

// ======================================================================
// Mouse side
// ======================================================================

// Quiet period before the nibble counter resyncs
`define CTRL_MOUSE_TO_BITS 15

`endif

// ==== hdl/ctrl_pad_pkg.sv ====
/* Types for host pad words and the console's answer nibbles.
   Referenced by scoped name from the scanner and the top level. */

`include "ctrl_macros.svh"

package ctrl_pad_pkg;

	// ======================================================================
	// Host pad word
	// ======================================================================

	// Bit layout, 1 means pressed
	//   [0] right  [1] left  [2] down  [3] up
	//   [4] I      [5] II    [6] select [7] run
	//   [8] III    [9] IV    [10] V    [11] VI
	typedef logic [`CTRL_PAD_BITS-1:0] pad_word_t;

	// ======================================================================
	// Console side
	// ======================================================================

	// Answer nibble on the data lines
	// Active low, the clear answer is all zero
	typedef logic [3:0] pad_nibble_t;

	// Multitap port number
	// Values past the last pad answer as an empty port
	typedef logic [2:0] port_index_t;

endpackage

// ==== hdl/ctrl_mouse_pkg.sv ====
/* Types for mouse motion, host mouse flags and the report nibble counter.
   Referenced by scoped name from the mouse stages and the scanner. */

package ctrl_mouse_pkg;

	// ======================================================================
	// Motion and buttons
	// ======================================================================

	// Motion count since the last sample, two's complement
	typedef logic signed [7:0] mouse_delta_t;

	// Host flags, bit 0 left button and bit 1 right button
	typedef logic [7:0] mouse_flags_t;

	// ======================================================================
	// Report sequencing
	// ======================================================================

	// 0 x upper, 1 x lower, 2 y upper, 3 y lower
	typedef logic [1:0] mouse_nibble_sel_t;

endpackage

// ==== hdl/mouse_motion_accumulator.sv ====
/* Holds the newest host mouse sample in console sign convention.
   The report latch empties it with take once the motion is reported. */

module mouse_motion_accumulator (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  ctrl_mouse_pkg::mouse_delta_t mouse_dx,
	input  ctrl_mouse_pkg::mouse_delta_t mouse_dy,
	input  logic                        mouse_strobe,
	input  logic                        take,
	output ctrl_mouse_pkg::mouse_delta_t pend_x,
	output ctrl_mouse_pkg::mouse_delta_t pend_y
);

	// Console counts x the other way round
	ctrl_mouse_pkg::mouse_delta_t dx_neg;

	assign dx_neg = -mouse_dx;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend_x <= '0;
			pend_y <= '0;
		end else if (mouse_strobe) begin
			// New sample beats a take in the same cycle
			pend_x <= dx_neg;
			pend_y <= mouse_dy;
		end else if (take) begin
			// Reported once, never again
			pend_x <= '0;
			pend_y <= '0;
		end
	end

endmodule

// ==== hdl/mouse_report_latch.sv ====
/* Holds the mouse report the console is reading and steps its nibbles.
   scan_start from the scanner advances the counter once per clear pulse. */

`include "ctrl_macros.svh"

module mouse_report_latch (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        pad_clr,
	input  logic                        scan_start,
	input  ctrl_mouse_pkg::mouse_delta_t pend_x,
	input  ctrl_mouse_pkg::mouse_delta_t pend_y,
	output logic                        take,
	output logic [3:0]                  report_nibble
);

	ctrl_mouse_pkg::mouse_nibble_sel_t nibble_cnt;
	ctrl_mouse_pkg::mouse_delta_t      report_x;
	ctrl_mouse_pkg::mouse_delta_t      report_y;
	logic [`CTRL_MOUSE_TO_BITS-1:0]    quiet_cnt;
	logic                              quiet_full;
	logic                              last_nibble;

	assign quiet_full  = &quiet_cnt;
	assign last_nibble = (nibble_cnt == 2'd3);

	// Report swap happens on the clear that follows the last nibble
	assign take = scan_start & last_nibble;

	// ======================================================================
	// Quiet timer and nibble counter
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quiet_cnt  <= '0;
			nibble_cnt <= 2'd3;
			report_x   <= '0;
			report_y   <= '0;
		end else begin
			if (pad_clr) begin
				quiet_cnt <= '0;
			end else if (!quiet_full) begin
				quiet_cnt <= quiet_cnt + 1'b1;
			end

			// Long pause, next read starts over at nibble 0
			if (quiet_full) begin
				nibble_cnt <= 2'd3;
			end

			if (scan_start) begin
				nibble_cnt <= nibble_cnt + 1'b1;
				if (last_nibble) begin
					report_x <= pend_x;
					report_y <= pend_y;
				end
			end
		end
	end

	// ======================================================================
	// Nibble select
	// ======================================================================

	always_comb begin
		case (nibble_cnt)
			2'd0:    report_nibble = report_x[7:4];
			2'd1:    report_nibble = report_x[3:0];
			2'd2:    report_nibble = report_y[7:4];
			default: report_nibble = report_y[3:0];
		endcase
	end

endmodule

// ==== hdl/pad_port_scanner.sv ====
/* Answers the console's select and clear lines with one registered nibble.
   Handles port stepping for the multitap, the six-button bank and mouse mode. */

`include "ctrl_macros.svh"

module pad_port_scanner (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  ctrl_pad_pkg::pad_word_t      pad_a,
	input  ctrl_pad_pkg::pad_word_t      pad_b,
	input  ctrl_pad_pkg::pad_word_t      pad_2,
	input  ctrl_pad_pkg::pad_word_t      pad_3,
	input  ctrl_pad_pkg::pad_word_t      pad_4,
	input  logic                         swap,
	input  logic                         multitap,
	input  logic                         six_button,
	input  logic                         mouse_en,
	input  ctrl_mouse_pkg::mouse_flags_t mouse_flags,
	input  logic [3:0]                   report_nibble,
	input  logic                         pad_sel,
	input  logic                         pad_clr,
	output logic                         scan_start,
	output ctrl_pad_pkg::pad_nibble_t    pad_nibble
);

	ctrl_pad_pkg::pad_word_t   host_pad [`CTRL_NUM_PADS];
	ctrl_pad_pkg::port_index_t port;
	logic                      bank;
	logic                      sel_q;
	logic                      clr_q;
	logic                      sel_rise;
	logic                      clr_rise;
	logic [3:0]                mouse_btn;
	logic [15:0]               answer;
	logic [3:0]                answer_idx;

	// Four answer nibbles of one pad, lowest nibble first
	function automatic logic [15:0] pad_answer(input ctrl_pad_pkg::pad_word_t w);
		pad_answer = {4'h0, ~w[11:8], ~{w[1], w[2], w[0], w[3]}, ~w[7:4]};
	endfunction

	// ======================================================================
	// Port map
	// ======================================================================

	assign host_pad[0] = swap ? pad_b : pad_a;
	assign host_pad[1] = swap ? pad_a : pad_b;
	assign host_pad[2] = pad_2;
	assign host_pad[3] = pad_3;
	assign host_pad[4] = pad_4;

	// Run, select, right, left
	assign mouse_btn = ~{host_pad[0][7], host_pad[0][6], mouse_flags[1], mouse_flags[0]};

	always_comb begin
		if (port == '0 && mouse_en) begin
			// Odd nibbles carry motion
			answer = {report_nibble, mouse_btn, report_nibble, mouse_btn};
		end else if (port < ctrl_pad_pkg::port_index_t'(`CTRL_NUM_PADS)) begin
			answer = pad_answer(host_pad[port]);
		end else begin
			// Empty multitap slot
			answer = 16'h0FFF;
		end
	end

	assign answer_idx = {bank, pad_sel, 2'b00};

	// ======================================================================
	// Protocol tracking
	// ======================================================================

	assign sel_rise = pad_sel & ~sel_q;
	assign clr_rise = pad_clr & ~clr_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q      <= 1'b0;
			clr_q      <= 1'b0;
			scan_start <= 1'b0;
			port       <= '0;
			bank       <= 1'b0;
			pad_nibble <= '0;
		end else begin
			sel_q      <= pad_sel;
			clr_q      <= pad_clr;
			scan_start <= clr_rise;

			if (pad_clr) begin
				port       <= '0;
				pad_nibble <= '0;
				// Six-button pads flip bank on every clear
				if (clr_rise) begin
					bank <= ~bank & six_button;
				end
			end else begin
				pad_nibble <= answer[answer_idx +: 4];
				if (sel_rise && multitap) begin
					port <= port + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/controller_port_top.sv ====
/* Controller port subsystem top level.
   Chains motion capture, report latch and pad scanner to the console lines. */

module controller_port_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  ctrl_pad_pkg::pad_word_t      pad_a,
	input  ctrl_pad_pkg::pad_word_t      pad_b,
	input  ctrl_pad_pkg::pad_word_t      pad_2,
	input  ctrl_pad_pkg::pad_word_t      pad_3,
	input  ctrl_pad_pkg::pad_word_t      pad_4,
	input  logic                         swap,
	input  logic                         multitap,
	input  logic                         six_button,
	input  logic                         mouse_en,
	input  ctrl_mouse_pkg::mouse_delta_t mouse_dx,
	input  ctrl_mouse_pkg::mouse_delta_t mouse_dy,
	input  ctrl_mouse_pkg::mouse_flags_t mouse_flags,
	input  logic                         mouse_strobe,
	input  logic                         pad_sel,
	input  logic                         pad_clr,
	output ctrl_pad_pkg::pad_nibble_t    pad_nibble
);

	ctrl_mouse_pkg::mouse_delta_t pend_x;
	ctrl_mouse_pkg::mouse_delta_t pend_y;
	logic                         take;
	logic [3:0]                   report_nibble;
	logic                         scan_start;

	mouse_motion_accumulator u_accum (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_strobe (mouse_strobe),
		.take         (take),
		.pend_x       (pend_x),
		.pend_y       (pend_y)
	);

	mouse_report_latch u_latch (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pad_clr       (pad_clr),
		.scan_start    (scan_start),
		.pend_x        (pend_x),
		.pend_y        (pend_y),
		.take          (take),
		.report_nibble (report_nibble)
	);

	pad_port_scanner u_scan (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pad_a         (pad_a),
		.pad_b         (pad_b),
		.pad_2         (pad_2),
		.pad_3         (pad_3),
		.pad_4         (pad_4),
		.swap          (swap),
		.multitap      (multitap),
		.six_button    (six_button),
		.mouse_en      (mouse_en),
		.mouse_flags   (mouse_flags),
		.report_nibble (report_nibble),
		.pad_sel       (pad_sel),
		.pad_clr       (pad_clr),
		.scan_start    (scan_start),
		.pad_nibble    (pad_nibble)
	);

endmodule

// ==== verification/controller_port_assertions.sv ====
/* Concurrent checks on the pad protocol outputs, bound into the top level.
   Failures raise $error and are counted for the testbench summary. */

module controller_port_assertions (
	input logic       clk_sys,
	input logic       reset,
	input logic       pad_clr,
	input logic [3:0] pad_nibble,
	input logic       scan_start
);

	timeunit 1ns;
	timeprecision 100ps;

	int clr_fails = 0;
	int reset_fails = 0;
	int start_fails = 0;
	int fail_count;

	assign fail_count = clr_fails + reset_fails + start_fails;

	// Clear answer is all zero one cycle later
	clr_zero: assert property (@(posedge clk_sys) disable iff (reset)
		pad_clr |=> (pad_nibble == 4'h0))
	else begin
		clr_fails++;
		$error("pad_nibble not zero one cycle after clear");
	end

	reset_zero: assert property (@(posedge clk_sys) reset |=> (pad_nibble == 4'h0))
	else begin
		reset_fails++;
		$error("pad_nibble not zero after reset");
	end

	// One scan_start per clear rising edge
	clr_start: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(pad_clr) |=> scan_start)
	else begin
		start_fails++;
		$error("scan_start missing after clear rising edge");
	end

endmodule

bind controller_port_top controller_port_assertions u_assertions (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.pad_clr    (pad_clr),
	.pad_nibble (pad_nibble),
	.scan_start (scan_start)
);

// ==== verification/tb_controller_port.sv ====
/* Testbench for the controller port top level.
   Walks the pad protocol and checks every answer nibble against a reference model. */

`include "ctrl_macros.svh"

module tb_controller_port;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int STEP_LIMIT   = 20;
	localparam int QUIET_CYCLES = (1 << `CTRL_MOUSE_TO_BITS) + 8;

	logic clk_sys = 1'b0;
	logic reset;
	ctrl_pad_pkg::pad_word_t      pad_a, pad_b, pad_2, pad_3, pad_4;
	logic                         swap, multitap, six_button, mouse_en;
	ctrl_mouse_pkg::mouse_delta_t mouse_dx, mouse_dy;
	ctrl_mouse_pkg::mouse_flags_t mouse_flags;
	logic                         mouse_strobe, pad_sel, pad_clr;
	ctrl_pad_pkg::pad_nibble_t    pad_nibble;

	// Reference model of port, bank and mouse report
	ctrl_pad_pkg::port_index_t         model_port;
	logic                              model_bank, model_sel, model_clr;
	ctrl_mouse_pkg::mouse_nibble_sel_t model_cnt;
	logic [7:0]                        model_rep_x, model_rep_y, model_pend_x, model_pend_y;

	logic [15:0] lfsr_state;
	int          req_count, done_count, check_count, error_count, assert_fails;
	logic        timed_out;

	controller_port_top u_controller_port_top (.*);

	always #20 clk_sys = ~clk_sys;

	// ======================================================================
	// Random source and reference
	// ======================================================================

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			w = (w << 1) | {15'd0, lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return w;
	endfunction

	function automatic logic [3:0] expected_nibble();
		ctrl_pad_pkg::pad_word_t w;
		logic [1:0]              idx;
		logic [3:0]              result;
		idx = {model_bank, model_sel};
		case (model_port)
			3'd0:    w = swap ? pad_b : pad_a;
			3'd1:    w = swap ? pad_a : pad_b;
			3'd2:    w = pad_2;
			3'd3:    w = pad_3;
			3'd4:    w = pad_4;
			default: w = '0;
		endcase
		if (model_clr) begin
			result = 4'h0;
		end else if (model_port == 3'd0 && mouse_en && !idx[0]) begin
			result = ~{w[7], w[6], mouse_flags[1], mouse_flags[0]};
		end else if (model_port == 3'd0 && mouse_en) begin
			case (model_cnt)
				2'd0:    result = model_rep_x[7:4];
				2'd1:    result = model_rep_x[3:0];
				2'd2:    result = model_rep_y[7:4];
				default: result = model_rep_y[3:0];
			endcase
		end else if (model_port >= 3'(`CTRL_NUM_PADS)) begin
			result = (idx == 2'd3) ? 4'h0 : 4'hF;
		end else begin
			case (idx)
				2'd0:    result = ~w[7:4];
				2'd1:    result = ~{w[1], w[2], w[0], w[3]};
				2'd2:    result = ~w[11:8];
				default: result = 4'h0;
			endcase
		end
		return result;
	endfunction

	// Two cycles after each step, sampled mid-cycle
	always begin : compare_answer
		logic [3:0] exp_nibble;
		@(posedge clk_sys);
		if (done_count < req_count) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp_nibble = expected_nibble();
			check_count++;
			assert (pad_nibble === exp_nibble) else begin
				error_count++;
				$display("ERR %0t: port %0d bank %0b sel %0b clr %0b gave %h, expected %h",
					$time, model_port, model_bank, model_sel, model_clr, pad_nibble, exp_nibble);
			end
			done_count++;
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic protocol_step(input logic sel, input logic clr);
		int target;
		int waited;
		if (!timed_out) begin
			@(posedge clk_sys);
			pad_sel <= sel;
			pad_clr <= clr;
			if (clr) begin
				model_port = '0;
				if (!model_clr) begin
					model_bank = six_button ? ~model_bank : 1'b0;
					if (model_cnt == 2'd3) begin
						model_rep_x  = model_pend_x;
						model_rep_y  = model_pend_y;
						model_pend_x = '0;
						model_pend_y = '0;
					end
					model_cnt = model_cnt + 2'd1;
				end
			end else if (sel && !model_sel && multitap) begin
				model_port = model_port + 3'd1;
			end
			model_sel = sel;
			model_clr = clr;
			target = done_count + 1;
			req_count <= req_count + 1;
			waited = 0;
			while (done_count < target && waited < STEP_LIMIT) begin
				@(posedge clk_sys);
				waited++;
			end
			if (done_count < target) begin
				timed_out = 1'b1;
				$display("Timeout: no answer check within %0d cycles of a step", STEP_LIMIT);
			end
		end
	endtask

	task automatic clear_pulse();
		protocol_step(1'b0, 1'b1);
		protocol_step(1'b0, 1'b0);
	endtask

	task automatic select_cycle();
		protocol_step(1'b1, 1'b0);
		protocol_step(1'b0, 1'b0);
	endtask

	task automatic set_options(input logic sw, input logic mt, input logic six, input logic ms);
		@(posedge clk_sys);
		swap       <= sw;
		multitap   <= mt;
		six_button <= six;
		mouse_en   <= ms;
	endtask

	task automatic load_random_pads();
		@(posedge clk_sys);
		pad_a       <= ctrl_pad_pkg::pad_word_t'(random_bits(12));
		pad_b       <= ctrl_pad_pkg::pad_word_t'(random_bits(12));
		pad_2       <= ctrl_pad_pkg::pad_word_t'(random_bits(12));
		pad_3       <= ctrl_pad_pkg::pad_word_t'(random_bits(12));
		pad_4       <= ctrl_pad_pkg::pad_word_t'(random_bits(12));
		mouse_flags <= ctrl_mouse_pkg::mouse_flags_t'(random_bits(8));
	endtask

	// Clear stays low until the quiet counter saturates
	task automatic wait_quiet_period();
		int cycles;
		if (!timed_out) begin
			cycles = 0;
			while (cycles < QUIET_CYCLES) begin
				@(posedge clk_sys);
				cycles++;
			end
			model_cnt = 2'd3;
		end
	endtask

	task automatic strobe_motion();
		ctrl_mouse_pkg::mouse_delta_t dx;
		ctrl_mouse_pkg::mouse_delta_t dy;
		dx = ctrl_mouse_pkg::mouse_delta_t'(random_bits(8));
		dy = ctrl_mouse_pkg::mouse_delta_t'(random_bits(8));
		@(posedge clk_sys);
		mouse_dx     <= dx;
		mouse_dy     <= dy;
		mouse_strobe <= 1'b1;
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
		model_pend_x = ~dx + 8'd1;
		model_pend_y = dy;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		reset = 1'b1;
		{swap, multitap, six_button, mouse_en, mouse_strobe, pad_sel, pad_clr} = '0;
		{pad_a, pad_b, pad_2, pad_3, pad_4} = '0;
		{mouse_dx, mouse_dy, mouse_flags} = '0;
		{model_port, model_bank, model_sel, model_clr} = '0;
		{model_rep_x, model_rep_y, model_pend_x, model_pend_y} = '0;
		model_cnt = 2'd3;
		lfsr_state = 16'd1348;
		{req_count, done_count, check_count, error_count} = '0;
		timed_out = 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Plain pad, then swapped
		for (int s = 0; s < 2; s++) begin
			set_options(s[0], 1'b0, 1'b0, 1'b0);
			repeat (4) begin
				load_random_pads();
				clear_pulse();
				select_cycle();
			end
		end

		// Multitap walks past the last pad
		for (int s = 0; s < 2; s++) begin
			set_options(s[0], 1'b1, 1'b0, 1'b0);
			load_random_pads();
			clear_pulse();
			repeat (6) select_cycle();
		end

		set_options(1'b0, 1'b0, 1'b1, 1'b0);
		load_random_pads();
		repeat (4) begin
			clear_pulse();
			select_cycle();
		end

		// Mouse report, then an empty one
		set_options(1'b0, 1'b0, 1'b0, 1'b1);
		load_random_pads();
		clear_pulse();
		wait_quiet_period();
		strobe_motion();
		repeat (8) begin
			clear_pulse();
			select_cycle();
		end

		assert_fails = u_controller_port_top.u_assertions.fail_count;
		$display("Checks %0d, value errors %0d, assertion failures %0d, timeout %0b",
			check_count, error_count, assert_fails, timed_out);
		if (error_count == 0 && assert_fails == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== pce_controller_port.f ====
+incdir+hdl
hdl/ctrl_pad_pkg.sv
hdl/ctrl_mouse_pkg.sv
hdl/mouse_motion_accumulator.sv
hdl/mouse_report_latch.sv
hdl/pad_port_scanner.sv
hdl/controller_port_top.sv
verification/controller_port_assertions.sv
verification/tb_controller_port.sv

// ==== Makefile ====
# Verilator flow for the controller port testbench

VERILATOR  := verilator
FLAGS      := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only
TOP        := tb_controller_port
FILELIST   := pce_controller_port.f
OBJ_DIR    := obj_dir
SIM_ARGS   := +verilator+error+limit+100
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
